/* all.f */
+incdir+.
ptw_pkg.sv
ptw_pte_check.sv
ptw_pmp_check.sv
ptw_walker.sv
ptw_top.sv
tb_ptw.sv

/* ptw_consts.svh */
// --------------------
// sv32 page-table walker constants
// address, entry and identifier widths shared by rtl and testbench
// --------------------
`ifndef PTW_CONSTS_SVH
`define PTW_CONSTS_SVH

// virtual address width of sv32
`define PTW_VLEN 32

// physical address width, sv32 reaches 34 bits
`define PTW_PLEN 34

// physical page number held in satp and in every entry
`define PTW_PPN_W 22

// one vpn slice indexes 1024 entries of a table
`define PTW_VPN_W 10

// two levels, level 0 is the root table
`define PTW_LEVELS 2

// address space identifier width in satp
`define PTW_ASID_W 9

// one page-table entry, also the read data width
`define PTW_PTE_W 32

// protection regions checked on every table read
`define PTW_PMP_N 4

`endif

/* ptw_pkg.sv */
// --------------------
// sv32 page-table walker types
// entry layout, fsm states, verdicts and port bundles
// --------------------
`include "ptw_consts.svh"

package ptw_pkg;

  // sv32 entry, msb first
  typedef struct packed {
    logic [`PTW_PPN_W-1:0] ppn;
    // reserved for software
    logic [1:0]            rsw;
    logic                  d;
    logic                  a;
    logic                  g;
    logic                  u;
    logic                  x;
    logic                  w;
    logic                  r;
    logic                  v;
  } sv32_pte_t;

  // outcome of classifying one fetched entry
  typedef enum logic [1:0] {
    VERDICT_POINTER,
    VERDICT_LEAF_OK,
    VERDICT_PAGE_FAULT
  } pte_verdict_e;

  // walker fsm
  typedef enum logic [2:0] {
    IDLE,
    WAIT_GRANT,
    PTE_LOOKUP,
    PROPAGATE_ERROR,
    PROPAGATE_ACCESS_ERROR,
    LATENCY
  } walk_state_e;

  // one protection region, limit is exclusive
  typedef struct packed {
    logic [`PTW_PLEN-1:0] base;
    logic [`PTW_PLEN-1:0] limit;
    logic                 r;
  } pmp_region_t;

  // tlb miss strobe with its context
  typedef struct packed {
    logic                  valid;
    logic [`PTW_VLEN-1:0]  vaddr;
    logic                  is_instr;
    logic                  is_store;
    logic [`PTW_ASID_W-1:0] asid;
    logic [`PTW_ASID_W-1:0] vs_asid;
    logic                  use_vs_asid;
  } miss_req_t;

  // refill towards the tlb
  typedef struct packed {
    logic                                valid;
    logic                                is_4m;
    logic [`PTW_LEVELS*`PTW_VPN_W-1:0]   vpn;
    logic [`PTW_ASID_W-1:0]              asid;
    sv32_pte_t                           content;
  } tlb_update_t;

  // memory port, request side
  typedef struct packed {
    logic                 req;
    logic [`PTW_PLEN-1:0] paddr;
  } mem_req_t;

  // memory port, response side
  typedef struct packed {
    logic                  gnt;
    logic                  rvalid;
    logic [`PTW_PTE_W-1:0] rdata;
  } mem_rsp_t;

endpackage

/* ptw_pmp_check.sv */
// --------------------
// walker protection check
// tests the current table read address against the region set
// walker reads are supervisor loads, so only r matters
// --------------------
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_pmp_check (
  // address of the table read in flight
  input  logic [`PTW_PLEN-1:0]                    paddr_i,
  input  ptw_pkg::pmp_region_t [`PTW_PMP_N-1:0]   pmp_cfg_i,
  output logic                                    allow_o
);

  // one bit per region that grants the read
  logic [`PTW_PMP_N-1:0] region_hit;
  // range match ignoring permission
  logic [`PTW_PMP_N-1:0] in_range;

  // --------------------
  // per region compare
  // --------------------
  // all regions are compared in parallel
  always_comb begin
    for (int unsigned i = 0; i < `PTW_PMP_N; i++) begin
      // base inclusive, limit exclusive
      in_range[i]   = (paddr_i >= pmp_cfg_i[i].base) &&
                      (paddr_i < pmp_cfg_i[i].limit);
      // a region without r never grants
      region_hit[i] = in_range[i] && pmp_cfg_i[i].r;
    end
  end

  // no priority between regions, any grant is enough
  // an empty region set denies everything
  assign allow_o = |region_hit;

endmodule

/* ptw_pte_check.sv */
// --------------------
// sv32 entry checker
// classifies one fetched entry as pointer, good leaf or page fault
// purely combinational
// --------------------
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_pte_check (
  input  ptw_pkg::sv32_pte_t    pte_i,
  // 0 for the root table, 1 for the second level
  input  logic                  level_i,
  input  logic                  is_instr_i,
  input  logic                  is_store_i,
  // make executable readable
  input  logic                  mxr_i,
  output ptw_pkg::pte_verdict_e verdict_o
);

  import ptw_pkg::*;

  logic is_leaf;
  logic last_level;
  logic bad_encoding;
  logic bad_pointer;
  logic misaligned;
  logic perm_fault;

  // r or x marks a leaf, otherwise the entry points one level down
  assign is_leaf    = pte_i.r | pte_i.x;
  assign last_level = (level_i == 1'(`PTW_LEVELS - 1));

  // invalid entry or reserved w-only encoding
  assign bad_encoding = !pte_i.v || (pte_i.w && !pte_i.r);

  // no level left below the second table
  assign bad_pointer = !is_leaf && last_level;

  // a 4 MiB leaf needs the low ppn slice cleared
  assign misaligned = is_leaf && (level_i == 1'b0) &&
                      (pte_i.ppn[`PTW_VPN_W-1:0] != '0);

  // --------------------
  // leaf permissions
  // --------------------
  always_comb begin
    perm_fault = 1'b0;
    // accessed bit is managed by software
    if (!pte_i.a) begin
      perm_fault = 1'b1;
    end
    if (is_instr_i) begin
      // fetch needs x
      if (!pte_i.x) begin
        perm_fault = 1'b1;
      end
    end else if (!(pte_i.r || (pte_i.x && mxr_i))) begin
      // load needs r, or x under mxr
      perm_fault = 1'b1;
    end
    // store needs w and a dirty page, dirty bit is software managed too
    if (is_store_i && !(pte_i.w && pte_i.d)) begin
      perm_fault = 1'b1;
    end
  end

  // --------------------
  // verdict
  // --------------------
  always_comb begin
    if (bad_encoding || bad_pointer) begin
      verdict_o = VERDICT_PAGE_FAULT;
    end else if (!is_leaf) begin
      verdict_o = VERDICT_POINTER;
    end else if (misaligned || perm_fault) begin
      verdict_o = VERDICT_PAGE_FAULT;
    end else begin
      verdict_o = VERDICT_LEAF_OK;
    end
  end

endmodule

/* ptw_top.sv */
// --------------------
// sv32 page-table walker top
// walk controller with entry and protection checkers side by side
// --------------------
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_top (
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  ptw_pkg::miss_req_t                    miss_req_i,
  input  logic [`PTW_PPN_W-1:0]                 satp_ppn_i,
  input  logic                                  mxr_i,
  input  ptw_pkg::pmp_region_t [`PTW_PMP_N-1:0] pmp_cfg_i,
  output ptw_pkg::mem_req_t                     mem_req_o,
  input  ptw_pkg::mem_rsp_t                     mem_rsp_i,
  output ptw_pkg::tlb_update_t                  tlb_update_o,
  output logic                                  ptw_error_o,
  output logic                                  ptw_access_exception_o,
  output logic                                  ptw_active_o,
  output logic [`PTW_PLEN-1:0]                  bad_paddr_o
);

  import ptw_pkg::*;

  // entry under test and its walk context
  sv32_pte_t    pte;
  logic         level;
  logic         is_instr;
  logic         is_store;
  // checker verdicts back to the fsm
  pte_verdict_e verdict;
  logic         allow;

  ptw_walker i_walker (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .miss_req_i             (miss_req_i),
    .satp_ppn_i             (satp_ppn_i),
    .mem_req_o              (mem_req_o),
    .mem_rsp_i              (mem_rsp_i),
    .pte_o                  (pte),
    .level_o                (level),
    .is_instr_o             (is_instr),
    .is_store_o             (is_store),
    .verdict_i              (verdict),
    .allow_i                (allow),
    .tlb_update_o           (tlb_update_o),
    .ptw_error_o            (ptw_error_o),
    .ptw_access_exception_o (ptw_access_exception_o),
    .ptw_active_o           (ptw_active_o),
    .bad_paddr_o            (bad_paddr_o)
  );

  ptw_pte_check i_pte_check (
    .pte_i      (pte),
    .level_i    (level),
    .is_instr_i (is_instr),
    .is_store_i (is_store),
    .mxr_i      (mxr_i),
    .verdict_o  (verdict)
  );

  // checks the read address the walker is driving
  ptw_pmp_check i_pmp_check (
    .paddr_i   (mem_req_o.paddr),
    .pmp_cfg_i (pmp_cfg_i),
    .allow_o   (allow)
  );

endmodule

/* ptw_walker.sv */
// --------------------
// sv32 walk controller
// issues table reads over the grant port, acts on the entry and
// protection verdicts and raises one result strobe per walk
// --------------------
`timescale 1ns/1ps
`include "ptw_consts.svh"

module ptw_walker (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  ptw_pkg::miss_req_t          miss_req_i,
  input  logic [`PTW_PPN_W-1:0]       satp_ppn_i,
  output ptw_pkg::mem_req_t           mem_req_o,
  input  ptw_pkg::mem_rsp_t           mem_rsp_i,
  // fetched entry and walk context towards the entry checker
  output ptw_pkg::sv32_pte_t          pte_o,
  output logic                        level_o,
  output logic                        is_instr_o,
  output logic                        is_store_o,
  input  ptw_pkg::pte_verdict_e       verdict_i,
  // protection verdict on the current read address
  input  logic                        allow_i,
  output ptw_pkg::tlb_update_t        tlb_update_o,
  output logic                        ptw_error_o,
  output logic                        ptw_access_exception_o,
  output logic                        ptw_active_o,
  output logic [`PTW_PLEN-1:0]        bad_paddr_o
);

  import ptw_pkg::*;

  // page offset below the vpn slices, 12 bits
  localparam int unsigned PgOffW = `PTW_VLEN - `PTW_LEVELS * `PTW_VPN_W;

  walk_state_e state_q, state_d;

  // walk context
  logic                   level_q, level_d;
  logic                   is_instr_q, is_instr_d;
  logic                   is_store_q, is_store_d;
  logic                   global_q, global_d;
  logic [`PTW_VLEN-1:0]   vaddr_q, vaddr_d;
  logic [`PTW_ASID_W-1:0] asid_q, asid_d;
  // word aligned pointer of the current table read
  logic [`PTW_PLEN-1:0]   pptr_q, pptr_d;

  // registered read port
  logic                   rvalid_q;
  logic [`PTW_PTE_W-1:0]  rdata_q;

  sv32_pte_t pte;
  logic      update_valid;
  logic [`PTW_VPN_W-1:0] vpn0;

  assign pte  = sv32_pte_t'(rdata_q);
  // low slice indexes the second table
  assign vpn0 = vaddr_q[PgOffW +: `PTW_VPN_W];

  // one read at a time, held until granted
  assign mem_req_o.req   = (state_q == WAIT_GRANT);
  assign mem_req_o.paddr = pptr_q;

  assign pte_o      = pte;
  assign level_o    = level_q;
  assign is_instr_o = is_instr_q;
  assign is_store_o = is_store_q;

  assign ptw_active_o = (state_q != IDLE);
  // denied pointer is kept in pptr_q until the exception strobe
  assign bad_paddr_o  = ptw_access_exception_o ? pptr_q : '0;

  // --------------------
  // tlb update
  // --------------------
  always_comb begin
    tlb_update_o.valid   = update_valid;
    // leaf found in the root table maps a superpage
    tlb_update_o.is_4m   = (level_q == 1'b0);
    tlb_update_o.vpn     = vaddr_q[`PTW_VLEN-1:PgOffW];
    tlb_update_o.asid    = asid_q;
    tlb_update_o.content = pte;
    // g on any level along the way makes the mapping global
    tlb_update_o.content.g = pte.g | global_q;
  end

  // --------------------
  // walk fsm
  // --------------------
  always_comb begin
    state_d                = state_q;
    level_d                = level_q;
    is_instr_d             = is_instr_q;
    is_store_d             = is_store_q;
    global_d               = global_q;
    vaddr_d                = vaddr_q;
    asid_d                 = asid_q;
    pptr_d                 = pptr_q;
    update_valid           = 1'b0;
    ptw_error_o            = 1'b0;
    ptw_access_exception_o = 1'b0;

    case (state_q)
      IDLE: begin
        // miss strobes are only seen here, busy walks ignore them
        if (miss_req_i.valid) begin
          level_d    = 1'b0;
          global_d   = 1'b0;
          is_instr_d = miss_req_i.is_instr;
          is_store_d = miss_req_i.is_store;
          vaddr_d    = miss_req_i.vaddr;
          asid_d     = miss_req_i.use_vs_asid ? miss_req_i.vs_asid : miss_req_i.asid;
          // root table entry indexed by vpn[1]
          pptr_d     = {satp_ppn_i, miss_req_i.vaddr[`PTW_VLEN-1 -: `PTW_VPN_W], 2'b00};
          state_d    = WAIT_GRANT;
        end
      end

      WAIT_GRANT: begin
        if (mem_rsp_i.gnt) begin
          state_d = PTE_LOOKUP;
        end
      end

      PTE_LOOKUP: begin
        // decide one cycle after rvalid, on the registered entry
        if (rvalid_q) begin
          if (!allow_i) begin
            // deny wins over any verdict, pointer stays for reporting
            state_d = PROPAGATE_ACCESS_ERROR;
          end else begin
            case (verdict_i)
              VERDICT_POINTER: begin
                global_d = global_q | pte.g;
                level_d  = 1'b1;
                pptr_d   = {pte.ppn, vpn0, 2'b00};
                state_d  = WAIT_GRANT;
              end
              VERDICT_LEAF_OK: begin
                update_valid = 1'b1;
                state_d      = LATENCY;
              end
              default: begin
                state_d = PROPAGATE_ERROR;
              end
            endcase
          end
        end
      end

      PROPAGATE_ERROR: begin
        ptw_error_o = 1'b1;
        state_d     = LATENCY;
      end

      PROPAGATE_ACCESS_ERROR: begin
        ptw_access_exception_o = 1'b1;
        state_d                = LATENCY;
      end

      // one idle cycle before the next miss can be taken
      LATENCY: begin
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  // --------------------
  // registers
  // --------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      level_q    <= 1'b0;
      is_instr_q <= 1'b0;
      is_store_q <= 1'b0;
      global_q   <= 1'b0;
      vaddr_q    <= '0;
      asid_q     <= '0;
      pptr_q     <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      state_q    <= state_d;
      level_q    <= level_d;
      is_instr_q <= is_instr_d;
      is_store_q <= is_store_d;
      global_q   <= global_d;
      vaddr_q    <= vaddr_d;
      asid_q     <= asid_d;
      pptr_q     <= pptr_d;
      rvalid_q   <= mem_rsp_i.rvalid;
    end
  end

  // read data only matters while rvalid_q is set
  always_ff @(posedge clk_i) begin
    rdata_q <= mem_rsp_i.rdata;
  end

endmodule

/* tb_ptw_checks.svh */
// --------------------
// compare tasks for the walker testbench
// one typed compare per kind of walk result
// --------------------
`ifndef TB_PTW_CHECKS_SVH
`define TB_PTW_CHECKS_SVH

// print the reason and the fail line before stopping the run
task automatic stop_on_error(input string msg);
  $display("%s", msg);
  $display("TESTS FAILED");
  $fatal(1, "simulation stopped at the first error");
endtask

// full tlb refill where a missing refill compares as all zero
task automatic check_update(input tlb_update_t got, input tlb_update_t exp,
                            input string what);
  string got_txt;
  string exp_txt;
  got_txt = $sformatf("v=%b 4m=%b vpn=%h asid=%h pte=%h",
                      got.valid, got.is_4m, got.vpn, got.asid, got.content);
  exp_txt = $sformatf("v=%b 4m=%b vpn=%h asid=%h pte=%h",
                      exp.valid, exp.is_4m, exp.vpn, exp.asid, exp.content);
  if (got !== exp) begin
    stop_on_error($sformatf("CHECK FAILED at %0d ns: %s update got %s, expected %s",
                            $time, what, got_txt, exp_txt));
  end
endtask

// single strobe or flag
task automatic check_fault(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("CHECK FAILED at %0d ns: %s got %b, expected %b",
                            $time, what, got, exp));
  end
endtask

// physical address of a table read
task automatic check_access(input logic [`PTW_PLEN-1:0] got,
                            input logic [`PTW_PLEN-1:0] exp, input string what);
  if (got !== exp) begin
    stop_on_error($sformatf("CHECK FAILED at %0d ns: %s got %h, expected %h",
                            $time, what, got, exp));
  end
endtask

`endif

/* tb_ptw.sv */
// --------------------
// sv32 page-table walker testbench
// sparse table memory with random grant and rvalid delays
// directed walks checked against expected refills and exceptions
// --------------------
`timescale 1ns/1ps
`include "ptw_consts.svh"

module tb_ptw;

  import ptw_pkg::*;

  // entry flag bits in the order of the low byte of an entry
  localparam logic [7:0] FL_V = 8'h01;
  localparam logic [7:0] FL_R = 8'h02;
  localparam logic [7:0] FL_W = 8'h04;
  localparam logic [7:0] FL_X = 8'h08;
  localparam logic [7:0] FL_G = 8'h20;
  localparam logic [7:0] FL_A = 8'h40;
  localparam logic [7:0] FL_D = 8'h80;

  // root table and second-level table pages
  localparam logic [`PTW_PPN_W-1:0] ROOT_PPN = 22'h00100;
  localparam logic [`PTW_PPN_W-1:0] L1_PPN   = 22'h00200;
  localparam int unsigned TIMEOUT = 200;

  logic                            clk;
  logic                            rst_n;
  miss_req_t                       miss_req;
  logic [`PTW_PPN_W-1:0]           satp_ppn;
  logic                            mxr;
  pmp_region_t [`PTW_PMP_N-1:0]    pmp_cfg;
  mem_req_t                        mem_req;
  mem_rsp_t                        mem_rsp;
  tlb_update_t                     tlb_update;
  logic                            ptw_error;
  logic                            ptw_acc;
  logic                            ptw_active;
  logic [`PTW_PLEN-1:0]            bad_paddr;

  // sparse table memory indexed by the byte address of each word
  logic [`PTW_PTE_W-1:0] pt_mem [logic [`PTW_PLEN-1:0]];
  logic [15:0]           lfsr_q;

  `include "tb_ptw_checks.svh"

  ptw_top dut0 (
    .clk_i                  (clk),
    .rst_ni                 (rst_n),
    .miss_req_i             (miss_req),
    .satp_ppn_i             (satp_ppn),
    .mxr_i                  (mxr),
    .pmp_cfg_i              (pmp_cfg),
    .mem_req_o              (mem_req),
    .mem_rsp_i              (mem_rsp),
    .tlb_update_o           (tlb_update),
    .ptw_error_o            (ptw_error),
    .ptw_access_exception_o (ptw_acc),
    .ptw_active_o           (ptw_active),
    .bad_paddr_o            (bad_paddr)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // fibonacci lfsr with taps 16 14 13 11
  // one step per bit taken
  function automatic logic [3:0] lfsr_bits(input int unsigned n);
    logic [3:0] bits;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
      bits   = {bits[2:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  // missing words read as zero and so as an invalid entry
  function automatic logic [`PTW_PTE_W-1:0] read_word(input logic [`PTW_PLEN-1:0] addr);
    if (pt_mem.exists(addr)) begin
      return pt_mem[addr];
    end
    return '0;
  endfunction

  // --------------------
  // memory model
  // --------------------
  // grant after 0..3 cycles and rvalid 1..3 cycles after the grant
  initial begin
    logic [`PTW_PLEN-1:0] addr;
    int unsigned          wait_cnt;
    lfsr_q  = 16'd77;
    mem_rsp = '0;
    forever begin
      @(negedge clk);
      if (rst_n && mem_req.req) begin
        addr     = mem_req.paddr;
        wait_cnt = lfsr_bits(2);
        repeat (wait_cnt) begin
          @(negedge clk);
          // request and address stay put while the grant is held back
          check_fault(mem_req.req, 1'b1, "request held until grant");
          check_access(mem_req.paddr, addr, "read address held until grant");
        end
        mem_rsp.gnt = 1'b1;
        @(negedge clk);
        mem_rsp.gnt = 1'b0;
        wait_cnt    = 1 + (lfsr_bits(2) % 3);
        repeat (wait_cnt - 1) @(negedge clk);
        mem_rsp.rdata  = read_word(addr);
        mem_rsp.rvalid = 1'b1;
        @(negedge clk);
        mem_rsp.rvalid = 1'b0;
      end
    end
  end

  // --------------------
  // entry and request builders
  // --------------------
  function automatic sv32_pte_t mk_pte(input logic [`PTW_PPN_W-1:0] ppn, input logic [7:0] fl);
    return sv32_pte_t'({ppn, 2'b00, fl});
  endfunction

  function automatic logic [`PTW_PLEN-1:0] pte_addr(input logic [`PTW_PPN_W-1:0] ppn,
                                                    input logic [`PTW_VPN_W-1:0] vpn);
    return {ppn, vpn, 2'b00};
  endfunction

  function automatic miss_req_t make_miss(input logic [31:0] vaddr, input logic is_instr,
                                          input logic is_store, input logic use_vs);
    miss_req_t m;
    m.valid       = 1'b1;
    m.vaddr       = vaddr;
    m.is_instr    = is_instr;
    m.is_store    = is_store;
    m.asid        = 9'h011;
    m.vs_asid     = 9'h1a0;
    m.use_vs_asid = use_vs;
    return m;
  endfunction

  // refill as the tlb should see it with g gathered from upper levels
  function automatic tlb_update_t expect_update(input miss_req_t m, input sv32_pte_t leaf,
                                                input logic is_4m, input logic upper_g);
    tlb_update_t u;
    u.valid     = 1'b1;
    u.is_4m     = is_4m;
    u.vpn       = m.vaddr[31:12];
    u.asid      = m.use_vs_asid ? m.vs_asid : m.asid;
    u.content   = leaf;
    u.content.g = leaf.g | upper_g;
    return u;
  endfunction

  // root pointer plus second-level leaf
  task automatic map_4k(input logic [31:0] vaddr, input logic [7:0] ptr_fl,
                        input sv32_pte_t leaf);
    pt_mem[pte_addr(ROOT_PPN, vaddr[31:22])] = mk_pte(L1_PPN, ptr_fl);
    pt_mem[pte_addr(L1_PPN, vaddr[21:12])]   = leaf;
  endtask

  task automatic map_4m(input logic [31:0] vaddr, input sv32_pte_t leaf);
    pt_mem[pte_addr(ROOT_PPN, vaddr[31:22])] = leaf;
  endtask

  // --------------------
  // walk sequencing
  // --------------------
  task automatic send_miss(input miss_req_t m);
    @(negedge clk);
    miss_req = m;
    @(negedge clk);
    miss_req.valid = 1'b0;
  endtask

  // wait for the result strobe and then for idle
  // any further strobe before idle is flagged
  task automatic collect_result(output tlb_update_t upd, output logic err,
                                output logic acc, output logic [`PTW_PLEN-1:0] bad);
    int unsigned cycles;
    logic        extra;
    upd    = '0;
    cycles = 0;
    extra  = 1'b0;
    while (!(tlb_update.valid || ptw_error || ptw_acc)) begin
      if (cycles == TIMEOUT) begin
        stop_on_error("no result strobe arrived from the walker before the timeout");
      end
      @(negedge clk);
      cycles++;
    end
    if (tlb_update.valid) begin
      upd = tlb_update;
    end
    err    = ptw_error;
    acc    = ptw_acc;
    bad    = bad_paddr;
    cycles = 0;
    @(negedge clk);
    while (ptw_active) begin
      if (tlb_update.valid || ptw_error || ptw_acc) begin
        extra = 1'b1;
      end
      if (cycles == TIMEOUT) begin
        stop_on_error("walker stayed active long after its result");
      end
      @(negedge clk);
      cycles++;
    end
    check_fault(extra, 1'b0, "second result strobe in one walk");
  endtask

  task automatic walk_and_check(input miss_req_t m, input tlb_update_t exp_upd,
                                input logic exp_err, input logic exp_acc,
                                input logic [`PTW_PLEN-1:0] exp_bad, input string name);
    tlb_update_t          upd;
    logic                 err;
    logic                 acc;
    logic [`PTW_PLEN-1:0] bad;
    send_miss(m);
    collect_result(upd, err, acc, bad);
    check_update(upd, exp_upd, name);
    check_fault(err, exp_err, {name, " page fault"});
    check_fault(acc, exp_acc, {name, " access exception"});
    check_access(bad, exp_bad, {name, " bad paddr"});
  endtask

  task automatic fault_case(input logic [31:0] vaddr, input logic is_instr,
                            input logic is_store, input string name);
    walk_and_check(make_miss(vaddr, is_instr, is_store, 1'b0), '0, 1'b1, 1'b0, '0, name);
  endtask

  // --------------------
  // directed tests
  // --------------------
  task automatic test_4k_walk();
    sv32_pte_t leaf;
    miss_req_t m;
    pt_mem.delete();
    leaf = mk_pte(22'h0abcd, FL_V | FL_R | FL_W | FL_A | FL_D);
    map_4k(32'h1234_5678, FL_V, leaf);
    m = make_miss(32'h1234_5678, 1'b0, 1'b0, 1'b0);
    walk_and_check(m, expect_update(m, leaf, 1'b0, 1'b0), 1'b0, 1'b0, '0, "4k asid");
    m = make_miss(32'h1234_5678, 1'b0, 1'b0, 1'b1);
    walk_and_check(m, expect_update(m, leaf, 1'b0, 1'b0), 1'b0, 1'b0, '0, "4k vs asid");
  endtask

  task automatic test_superpage_global();
    sv32_pte_t leaf;
    miss_req_t m;
    pt_mem.delete();
    leaf = mk_pte(22'h12c00, FL_V | FL_R | FL_X | FL_A);
    map_4m(32'h8040_1234, leaf);
    m = make_miss(32'h8040_1234, 1'b0, 1'b0, 1'b0);
    walk_and_check(m, expect_update(m, leaf, 1'b1, 1'b0), 1'b0, 1'b0, '0, "superpage");
    // g only on the pointer entry
    leaf = mk_pte(22'h05555, FL_V | FL_R | FL_A);
    map_4k(32'h0040_3000, FL_V | FL_G, leaf);
    m = make_miss(32'h0040_3000, 1'b0, 1'b0, 1'b0);
    walk_and_check(m, expect_update(m, leaf, 1'b0, 1'b1), 1'b0, 1'b0, '0, "global");
  endtask

  task automatic test_page_faults();
    pt_mem.delete();
    map_4k(32'h0100_1000, FL_V, mk_pte(22'h00011, FL_R | FL_A));
    fault_case(32'h0100_1000, 1'b0, 1'b0, "v clear");
    // x makes it an executable leaf so only the w without r rule can fault it
    map_4k(32'h0200_2000, FL_V, mk_pte(22'h00012, FL_V | FL_W | FL_X | FL_A));
    fault_case(32'h0200_2000, 1'b1, 1'b0, "w without r");
    map_4k(32'h0300_3000, FL_V, mk_pte(22'h00300, FL_V));
    // good leaf that only a third table read would reach
    pt_mem[pte_addr(22'h00300, 10'h003)] = mk_pte(22'h00013, FL_V | FL_R | FL_A);
    fault_case(32'h0300_3000, 1'b0, 1'b0, "pointer at level 1");
    map_4m(32'h0400_0000, mk_pte(22'h12c01, FL_V | FL_R | FL_A));
    fault_case(32'h0400_0000, 1'b0, 1'b0, "misaligned superpage");
    map_4k(32'h0500_5000, FL_V, mk_pte(22'h00015, FL_V | FL_R));
    fault_case(32'h0500_5000, 1'b0, 1'b0, "a clear");
    map_4k(32'h0600_6000, FL_V, mk_pte(22'h00016, FL_V | FL_R | FL_W | FL_A));
    fault_case(32'h0600_6000, 1'b0, 1'b1, "store to clean page");
  endtask

  task automatic test_exec_mxr();
    sv32_pte_t leaf;
    miss_req_t m;
    pt_mem.delete();
    map_4k(32'h0700_7000, FL_V, mk_pte(22'h00017, FL_V | FL_R | FL_A));
    fault_case(32'h0700_7000, 1'b1, 1'b0, "fetch without x");
    leaf = mk_pte(22'h00018, FL_V | FL_X | FL_A);
    map_4k(32'h0800_8000, FL_V, leaf);
    fault_case(32'h0800_8000, 1'b0, 1'b0, "load exec-only mxr clear");
    mxr = 1'b1;
    m   = make_miss(32'h0800_8000, 1'b0, 1'b0, 1'b0);
    walk_and_check(m, expect_update(m, leaf, 1'b0, 1'b0), 1'b0, 1'b0, '0, "load mxr set");
    mxr = 1'b0;
  endtask

  task automatic test_pmp_deny();
    miss_req_t m;
    pt_mem.delete();
    map_4k(32'h0900_9000, FL_V, mk_pte(22'h00019, FL_V | FL_R | FL_A));
    // only the root table page stays readable
    pmp_cfg          = '0;
    pmp_cfg[0].base  = {ROOT_PPN, 12'h000};
    pmp_cfg[0].limit = {ROOT_PPN, 12'h000} + 34'h1000;
    pmp_cfg[0].r     = 1'b1;
    m = make_miss(32'h0900_9000, 1'b0, 1'b0, 1'b0);
    walk_and_check(m, '0, 1'b0, 1'b1, pte_addr(L1_PPN, m.vaddr[21:12]), "pmp deny");
    set_pmp_open();
  endtask

  task automatic test_busy_backpressure();
    sv32_pte_t            leaf;
    miss_req_t            m;
    tlb_update_t          upd;
    logic                 err;
    logic                 acc;
    logic [`PTW_PLEN-1:0] bad;
    pt_mem.delete();
    leaf = mk_pte(22'h0beef, FL_V | FL_R | FL_A);
    map_4k(32'h0a00_a000, FL_V, leaf);
    map_4k(32'h0b00_b000, FL_V, mk_pte(22'h0cafe, FL_V | FL_R | FL_A));
    m = make_miss(32'h0a00_a000, 1'b0, 1'b0, 1'b0);
    send_miss(m);
    check_fault(ptw_active, 1'b1, "active after accepted miss");
    send_miss(make_miss(32'h0b00_b000, 1'b0, 1'b0, 1'b1));
    collect_result(upd, err, acc, bad);
    check_update(upd, expect_update(m, leaf, 1'b0, 1'b0), "busy first walk");
    check_fault(err, 1'b0, "busy page fault");
    check_fault(acc, 1'b0, "busy access exception");
    check_access(bad, '0, "busy bad paddr");
    // the ignored miss must not start a walk later
    repeat (10) begin
      @(negedge clk);
      check_fault(ptw_active, 1'b0, "miss during busy walk ignored");
    end
    // each repeat sees different grant and rvalid delays
    repeat (6) begin
      walk_and_check(m, expect_update(m, leaf, 1'b0, 1'b0), 1'b0, 1'b0, '0, "random delays");
    end
  endtask

  task automatic set_pmp_open();
    pmp_cfg          = '0;
    pmp_cfg[0].limit = 34'h3_ffff_ffff;
    pmp_cfg[0].r     = 1'b1;
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    rst_n    = 1'b0;
    miss_req = '0;
    satp_ppn = ROOT_PPN;
    mxr      = 1'b0;
    set_pmp_open();
    repeat (16) @(negedge clk);
    rst_n = 1'b1;
    test_4k_walk();
    test_superpage_global();
    test_page_faults();
    test_exec_mxr();
    test_pmp_deny();
    test_busy_backpressure();
    $display("TESTS PASSED");
    $finish;
  end

endmodule
